//--- Bender.yml
package:
  name: stream_dma

sources:
  - include_dirs:
      - .
    files:
      - dma_pkg.sv
      - dma_stream_if.sv
      - channel_selector.sv
      - beat_packer.sv
      - burst_writer.sv
      - stream_dma.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_stream_dma.sv

//--- beat_packer.sv
// Beat packer, second pipeline stage
// Pairs consecutive 64-bit tagged words into one 128-bit bus beat, earlier word
// in the low half, and forwards the end of frame marker of the second word

`timescale 1ns/10ps
`default_nettype none

module beat_packer
    import dma_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    dma_stream_if.slave  word_in,
    dma_stream_if.master beat_out
);

    word_t first_word;
    logic  have_first;
    logic  take;

    // A first word can always be parked, a second one needs a free beat register
    assign word_in.ready = !have_first || !beat_out.valid || beat_out.ready;
    assign take          = word_in.valid && word_in.ready;

    ////////////////////////////////////////
    // Pair tracking and beat handshake
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            have_first     <= 1'b0;
            beat_out.valid <= 1'b0;
            beat_out.last  <= 1'b0;
        end else begin
            if (beat_out.valid && beat_out.ready) begin
                beat_out.valid <= 1'b0;
                beat_out.last  <= 1'b0;
            end
            if (take) begin
                if (have_first) begin
                    have_first     <= 1'b0;
                    beat_out.valid <= 1'b1;
                    beat_out.last  <= word_in.last;
                end else begin
                    have_first <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take && !have_first) begin
            first_word <= word_in.data;
        end
        if (take && have_first) begin
            beat_out.data <= {word_in.data, first_word};
        end
    end

    // The selector's frame length keeps the final word on an odd position
    last_on_second_word: assert property (
        @(posedge clock) disable iff (!reset)
        take && !have_first |-> !word_in.last
    );

endmodule

`default_nettype wire

//--- burst_writer.sv
// Burst writer, third pipeline stage
// Starts a frame on buffer_full, streams beats out as fixed-length AXI4 INCR
// write bursts from the base address, and reports done and error per frame

`timescale 1ns/10ps
`default_nettype none

`include "dma_settings.svh"

module burst_writer
    import dma_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         buffer_full,
    input  logic         disable_dma,
    input  addr_t        dma_base_addr,
    output logic         frame_start,
    dma_stream_if.slave  beat_in,
    output addr_t        awaddr,
    output logic         awvalid,
    input  logic         awready,
    output beat_t        wdata,
    output logic         wlast,
    output logic         wvalid,
    input  logic         wready,
    input  logic [1:0]   bresp,
    input  logic         bvalid,
    output logic         bready,
    output logic         dma_done,
    output logic         dma_error
);

    localparam int BURSTS_PER_FRAME =
        `DMA_N_CHANNELS * `DMA_CHANNEL_SAMPLES / (2 * `DMA_BURST_LEN);
    localparam int BURST_W = $clog2(BURSTS_PER_FRAME + 1);
    localparam int BEAT_W  = $clog2(`DMA_BURST_LEN + 1);
    localparam logic [BEAT_W-1:0] BEATS     = BEAT_W'(`DMA_BURST_LEN);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`DMA_BURST_LEN - 1);
    // Each beat is 16 bytes
    localparam addr_t BURST_BYTES = addr_t'(16 * `DMA_BURST_LEN);

    writer_state_t       state;
    addr_t               base_addr;
    logic [BURST_W-1:0]  burst_count;
    logic [BEAT_W-1:0]   beat_count;
    logic                frame_last;
    logic                frame_go;
    logic                beat_take;

    assign frame_go = (state == writer_idle) && buffer_full && !disable_dma;

    // Pull a beat only while the burst still needs one and the W register frees up
    assign beat_in.ready = (state == writer_data) && (beat_count < BEATS)
                           && (!wvalid || wready);
    assign beat_take     = beat_in.valid && beat_in.ready;

    assign bready = (state == writer_response);

    ////////////////////////////////////////
    // Writer FSM
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            state       <= writer_idle;
            frame_start <= 1'b0;
            awvalid     <= 1'b0;
            wvalid      <= 1'b0;
            wlast       <= 1'b0;
            dma_done    <= 1'b0;
            dma_error   <= 1'b0;
            burst_count <= '0;
            beat_count  <= '0;
            frame_last  <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            dma_done    <= 1'b0;
            case (state)
                writer_idle: begin
                    if (frame_go) begin
                        frame_start <= 1'b1;
                        dma_error   <= 1'b0;
                        burst_count <= '0;
                        state       <= writer_address;
                    end
                end
                writer_address: begin
                    if (!awvalid) begin
                        awvalid <= 1'b1;
                    end else if (awready) begin
                        awvalid    <= 1'b0;
                        beat_count <= '0;
                        state      <= writer_data;
                    end
                end
                writer_data: begin
                    if (beat_take) begin
                        wvalid     <= 1'b1;
                        wlast      <= (beat_count == LAST_BEAT);
                        frame_last <= beat_in.last;
                        beat_count <= beat_count + 1'b1;
                    end else if (wvalid && wready) begin
                        wvalid <= 1'b0;
                        wlast  <= 1'b0;
                        if (wlast) begin
                            state <= writer_response;
                        end
                    end
                end
                writer_response: begin
                    if (bvalid) begin
                        // Anything but OKAY marks the frame as failed
                        if (bresp != 2'b00) begin
                            dma_error <= 1'b1;
                        end
                        if (frame_last) begin
                            dma_done <= 1'b1;
                            state    <= writer_finish;
                        end else begin
                            burst_count <= burst_count + 1'b1;
                            state       <= writer_address;
                        end
                    end
                end
                writer_finish: begin
                    state <= writer_idle;
                end
                default: begin
                    state <= writer_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Address and data registers
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (frame_go) begin
            base_addr <= dma_base_addr;
        end
        if (state == writer_address && !awvalid) begin
            awaddr <= base_addr + addr_t'(burst_count) * BURST_BYTES;
        end
        if (beat_take) begin
            wdata <= beat_in.data;
        end
    end

    // AXI4 forbids dropping or changing a pending write address
    aw_held_until_ready: assert property (
        @(posedge clock) disable iff (!reset)
        awvalid && !awready |=> awvalid && $stable(awaddr)
    );

    wlast_needs_wvalid: assert property (
        @(posedge clock) disable iff (!reset)
        wlast |-> wvalid
    );

endmodule

`default_nettype wire

//--- channel_selector.sv
// Channel selector, first pipeline stage
// Drains each input channel in turn for one frame, tags every sample with its
// user field and channel number, and flags the final word of the frame

`timescale 1ns/10ps
`default_nettype none

`include "dma_settings.svh"

module channel_selector
    import dma_pkg::*;
(
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             frame_start,
    input  sample_t [`DMA_N_CHANNELS-1:0]    channel_data,
    input  tag_t    [`DMA_N_CHANNELS-1:0]    channel_user,
    input  logic    [`DMA_N_CHANNELS-1:0]    channel_valid,
    output logic    [`DMA_N_CHANNELS-1:0]    channel_ready,
    dma_stream_if.master                     word_out
);

    localparam int COUNT_W = $clog2(`DMA_CHANNEL_SAMPLES);
    localparam logic [COUNT_W-1:0] LAST_SAMPLE = COUNT_W'(`DMA_CHANNEL_SAMPLES - 1);
    localparam channel_t LAST_CHANNEL = channel_t'(`DMA_N_CHANNELS - 1);

    logic                armed;
    channel_t            channel;
    logic [COUNT_W-1:0]  sample_count;
    logic                can_accept;
    logic                take;
    logic                final_word;

    // The output register is free when empty or when its word leaves this cycle
    assign can_accept = armed && (!word_out.valid || word_out.ready);
    assign take       = can_accept && channel_valid[channel];
    assign final_word = (sample_count == LAST_SAMPLE) && (channel == LAST_CHANNEL);

    // Only the channel being drained sees ready
    always_comb begin
        channel_ready = '0;
        channel_ready[channel] = can_accept;
    end

    ////////////////////////////////////////
    // Frame position
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            armed        <= 1'b0;
            channel      <= '0;
            sample_count <= '0;
        end else if (frame_start) begin
            armed        <= 1'b1;
            channel      <= '0;
            sample_count <= '0;
        end else if (take) begin
            if (sample_count == LAST_SAMPLE) begin
                sample_count <= '0;
                if (channel == LAST_CHANNEL) begin
                    armed <= 1'b0;
                end else begin
                    channel <= channel + 1'b1;
                end
            end else begin
                sample_count <= sample_count + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            word_out.valid <= 1'b0;
            word_out.last  <= 1'b0;
        end else if (take) begin
            word_out.valid <= 1'b1;
            word_out.last  <= final_word;
        end else if (word_out.ready) begin
            word_out.valid <= 1'b0;
            word_out.last  <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            word_out.data <= {channel_user[channel], tag_t'(channel), channel_data[channel]};
        end
    end

    // The index must stay inside the channel arrays for the whole frame
    channel_in_range: assert property (
        @(posedge clock) disable iff (!reset)
        armed |=> int'(channel) < `DMA_N_CHANNELS
    );

    // Between frames no source may be handshaken
    no_ready_when_disarmed: assert property (
        @(posedge clock) disable iff (!reset)
        !armed |-> channel_ready == '0
    );

endmodule

`default_nettype wire

//--- dma_pkg.sv
// Stream DMA types
// Data widths of samples, tagged words and bus beats, plus the writer FSM states

`default_nettype none

`include "dma_settings.svh"

package dma_pkg;

    ////////////////////////////////////////
    // Data path widths
    ////////////////////////////////////////

    // Raw sample from one input channel
    typedef logic [31:0] sample_t;

    // User field or widened channel index
    typedef logic [15:0] tag_t;

    // Tagged word, laid out as {user, channel, sample}
    typedef logic [63:0] word_t;

    // Bus beat holding two words, the earlier one in the low half
    typedef logic [127:0] beat_t;

    // Byte address on the AXI4 side
    typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;

    // Index of the channel currently being drained
    typedef logic [$clog2(`DMA_N_CHANNELS)-1:0] channel_t;

    ////////////////////////////////////////
    // Burst writer FSM
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        writer_idle,
        writer_address,
        writer_data,
        writer_response,
        writer_finish
    } writer_state_t;

endpackage

`default_nettype wire

//--- dma_settings.svh
// Stream DMA configuration
// Channel count, burst geometry, frame size and address width shared by every stage

`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// Number of input sample channels
`define DMA_N_CHANNELS 4

// Beats in every AXI4 write burst
`define DMA_BURST_LEN 4

// Words taken from each channel in one frame
// Must be even, and N_CHANNELS * CHANNEL_SAMPLES / 2 must divide evenly into bursts
`define DMA_CHANNEL_SAMPLES 16

// Byte address width of the AXI4 master
`define DMA_ADDR_WIDTH 32

`endif

//--- dma_stream_if.sv
// Valid/ready stream link between pipeline stages
// Carries a payload of WIDTH bits and an end of frame marker

`timescale 1ns/10ps
`default_nettype none

interface dma_stream_if #(
    parameter int WIDTH = 64
) ();

    logic [WIDTH-1:0] data;
    logic             last;
    logic             valid;
    logic             ready;

    // Producer side holds valid and data until the transfer
    modport master (
        output data,
        output last,
        output valid,
        input  ready
    );

    // Consumer side only drives ready
    modport slave (
        input  data,
        input  last,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

//--- src.f
+incdir+.
dma_pkg.sv
dma_stream_if.sv
channel_selector.sv
beat_packer.sv
burst_writer.sv
stream_dma.sv
tb_stream_dma.sv

//--- stream_dma.sv
// Multichannel streaming DMA, top level
// Channel selector, beat packer and burst writer chained by stream links,
// with flat channel vectors and the AXI4 write signals as plain ports

`timescale 1ns/10ps
`default_nettype none

`include "dma_settings.svh"

module stream_dma
    import dma_pkg::*;
(
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             buffer_full,
    input  logic                             disable_dma,
    input  addr_t                            dma_base_addr,
    input  logic [`DMA_N_CHANNELS*32-1:0]    channel_data,
    input  logic [`DMA_N_CHANNELS*16-1:0]    channel_user,
    input  logic [`DMA_N_CHANNELS-1:0]       channel_valid,
    output logic [`DMA_N_CHANNELS-1:0]       channel_ready,
    output addr_t                            awaddr,
    output logic                             awvalid,
    input  logic                             awready,
    output beat_t                            wdata,
    output logic                             wlast,
    output logic                             wvalid,
    input  logic                             wready,
    input  logic [1:0]                       bresp,
    input  logic                             bvalid,
    output logic                             bready,
    output logic                             dma_done,
    output logic                             dma_error
);

    logic frame_start;

    dma_stream_if #(.WIDTH($bits(word_t))) word_stream ();
    dma_stream_if #(.WIDTH($bits(beat_t))) beat_stream ();

    channel_selector channel_selector_inst (
        .clock         (clock),
        .reset         (reset),
        .frame_start   (frame_start),
        .channel_data  (channel_data),
        .channel_user  (channel_user),
        .channel_valid (channel_valid),
        .channel_ready (channel_ready),
        .word_out      (word_stream.master)
    );

    beat_packer beat_packer_inst (
        .clock    (clock),
        .reset    (reset),
        .word_in  (word_stream.slave),
        .beat_out (beat_stream.master)
    );

    burst_writer burst_writer_inst (
        .clock         (clock),
        .reset         (reset),
        .buffer_full   (buffer_full),
        .disable_dma   (disable_dma),
        .dma_base_addr (dma_base_addr),
        .frame_start   (frame_start),
        .beat_in       (beat_stream.slave),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wlast         (wlast),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .dma_done      (dma_done),
        .dma_error     (dma_error)
    );

endmodule

`default_nettype wire

//--- tb_stream_dma.sv
// Testbench for the multichannel stream DMA
// Random channel sources, an AXI4 write memory model with random back-pressure,
// and a reference model of the expected beat at every frame address

`timescale 1ns/10ps
`default_nettype none

`include "dma_settings.svh"

module tb_stream_dma
    import dma_pkg::*;
();

    localparam int N_CH         = `DMA_N_CHANNELS;
    localparam int CS           = `DMA_CHANNEL_SAMPLES;
    localparam int BL           = `DMA_BURST_LEN;
    localparam int FRAME_BEATS  = N_CH * CS / 2;
    localparam int FRAME_BURSTS = FRAME_BEATS / BL;
    localparam int FRAME_BYTES  = FRAME_BEATS * 16;
    localparam int TIMEOUT      = 5000;

    logic                clock;
    logic                reset;
    logic                buffer_full;
    logic                disable_dma;
    addr_t               dma_base_addr;
    logic [N_CH*32-1:0]  channel_data;
    logic [N_CH*16-1:0]  channel_user;
    logic [N_CH-1:0]     channel_valid;
    logic [N_CH-1:0]     channel_ready;
    addr_t               awaddr;
    logic                awvalid;
    logic                awready;
    beat_t               wdata;
    logic                wlast;
    logic                wvalid;
    logic                wready;
    logic [1:0]          bresp;
    logic                bvalid;
    logic                bready;
    logic                dma_done;
    logic                dma_error;

    integer          seed = 32'h4e4ec5b3;
    logic            random_mode;
    sample_t         frame_samples [N_CH][CS];
    tag_t            channel_users [N_CH];
    int              src_index [N_CH];
    logic [N_CH-1:0] src_fire;
    logic            b_fire;
    logic            pending_b;
    int              b_index;
    int              error_burst;
    beat_t           mem [addr_t];
    addr_t           burst_addrs [$];
    int              burst_beats [$];
    addr_t           cur_addr;
    int              w_beat;
    int              done_count;
    int              aw_cycles;
    addr_t           current_base;
    string           test_name;
    int              errors;
    int              test_errors;
    int              tests_passed;
    int              tests_failed;

    stream_dma stream_dma_inst (.*);

    always #5 clock = ~clock;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Beat k holds frame words 2k and 2k+1, channels drained in order
    function automatic beat_t expected_beat(input addr_t base, input addr_t addr);
        int    k;
        int    w;
        int    ch;
        word_t words [2];
        k = int'((addr - base) / 16);
        for (int i = 0; i < 2; i++) begin
            w = 2 * k + i;
            ch = w / CS;
            words[i] = {channel_users[ch], tag_t'(ch), frame_samples[ch][w % CS]};
        end
        return {words[1], words[0]};
    endfunction

    function automatic logic pick_high();
        if (!random_mode) begin
            return 1'b1;
        end
        return ($random(seed) % 4) != 0;
    endfunction

    ////////////////////////////////////////
    // Monitor, sampled at the rising edge
    ////////////////////////////////////////

    always @(posedge clock) begin
        src_fire = channel_valid & channel_ready;
        b_fire   = bvalid && bready;
        if (reset) begin
            // bready belongs to the response phase of a burst whose last beat was taken
            if (bready && !pending_b) begin
                $display("ERROR: %s: bready was high with no write response due", test_name);
                errors++;
            end
            if (dma_done) begin
                done_count++;
            end
            if (awvalid) begin
                aw_cycles++;
            end
            if (awvalid && awready) begin
                burst_addrs.push_back(awaddr);
                cur_addr = awaddr;
                w_beat   = 0;
            end
            if (wvalid && wready) begin
                mem[cur_addr + addr_t'(16 * w_beat)] = wdata;
                if (wlast != (w_beat == BL - 1)) begin
                    $display("CHECK FAILED %s: wlast on beat %0d of burst at %h expected %b actual %b",
                             test_name, w_beat, cur_addr, w_beat == BL - 1, wlast);
                    errors++;
                end
                w_beat++;
                if (wlast) begin
                    burst_beats.push_back(w_beat);
                    pending_b = 1'b1;
                end
            end
            if (b_fire) begin
                pending_b = 1'b0;
                b_index++;
            end
        end
    end

    ////////////////////////////////////////
    // Sources and memory model, driven at the falling edge
    ////////////////////////////////////////

    always @(negedge clock) begin
        if (reset) begin
            for (int c = 0; c < N_CH; c++) begin
                if (src_fire[c]) begin
                    src_index[c]++;
                end
                // A raised valid stays up with its data until the transfer
                if (src_fire[c] || !channel_valid[c]) begin
                    if (src_index[c] < CS) begin
                        channel_valid[c] = pick_high();
                        channel_data[c*32 +: 32] = frame_samples[c][src_index[c]];
                    end else begin
                        channel_valid[c] = 1'b0;
                    end
                end
            end
            awready = pick_high();
            wready  = pick_high();
            if (b_fire) begin
                bvalid = 1'b0;
            end else if (!bvalid && pending_b) begin
                bvalid = 1'b1;
                bresp  = (b_index == error_burst) ? 2'b10 : 2'b00;
            end
        end
    end

    ////////////////////////////////////////
    // Test tasks
    ////////////////////////////////////////

    task automatic load_frame(input logic fresh);
        for (int c = 0; c < N_CH; c++) begin
            src_index[c] = 0;
            for (int s = 0; s < CS && fresh; s++) begin
                frame_samples[c][s] = $random(seed);
            end
        end
        mem.delete();
        burst_addrs.delete();
        burst_beats.delete();
        b_index = 0;
    endtask

    task automatic abort_run(input string reason);
        $display("ERROR: %s: %s, run stopped", test_name, reason);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic wait_started();
        int cycles;
        cycles = 0;
        while (!awvalid && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (!awvalid) begin
            abort_run("the frame never issued a write address");
        end
    endtask

    task automatic wait_done();
        int cycles;
        int start;
        cycles = 0;
        start = done_count;
        while (done_count == start && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (done_count == start) begin
            abort_run("dma_done never arrived");
        end else begin
            repeat (5) @(negedge clock);
            if (done_count != start + 1) begin
                $display("CHECK FAILED %s: dma_done pulses expected 1 actual %0d",
                         test_name, done_count - start);
                errors++;
            end
        end
    endtask

    task automatic run_frame(input addr_t base);
        current_base  = base;
        dma_base_addr = base;
        buffer_full   = 1'b1;
        wait_started();
        buffer_full = 1'b0;
        wait_done();
    endtask

    task automatic compare_memory();
        addr_t addr;
        beat_t expected;
        for (int k = 0; k < FRAME_BEATS; k++) begin
            addr = current_base + addr_t'(16 * k);
            expected = expected_beat(current_base, addr);
            if (!mem.exists(addr)) begin
                $display("ERROR: %s: no beat was written at %h", test_name, addr);
                errors++;
            end else if (mem[addr] !== expected) begin
                $display("CHECK FAILED %s: beat at %h expected %h actual %h",
                         test_name, addr, expected, mem[addr]);
                errors++;
            end
        end
        foreach (mem[a]) begin
            if (a < current_base || a >= current_base + addr_t'(FRAME_BYTES)) begin
                $display("ERROR: %s: a beat was written outside the frame at %h",
                         test_name, a);
                errors++;
            end
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            tests_passed++;
            $display("[%s] passed", test_name);
        end else begin
            tests_failed++;
            $display("[%s] failed with %0d errors", test_name, errors - test_errors);
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        clock         = 1'b0;
        reset         = 1'b0;
        buffer_full   = 1'b0;
        disable_dma   = 1'b0;
        dma_base_addr = '0;
        channel_data  = '0;
        channel_valid = '0;
        awready       = 1'b0;
        wready        = 1'b0;
        bresp         = 2'b00;
        bvalid        = 1'b0;
        src_fire      = '0;
        b_fire        = 1'b0;
        pending_b     = 1'b0;
        error_burst   = -1;
        random_mode   = 1'b0;
        done_count    = 0;
        aw_cycles     = 0;
        errors        = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        for (int c = 0; c < N_CH; c++) begin
            channel_users[c] = tag_t'(16'h5a00 + c);
            channel_user[c*16 +: 16] = channel_users[c];
            // Sources stay idle until the first frame is loaded
            src_index[c] = CS;
        end
        repeat (2) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);

        begin_test("single frame, no back-pressure");
        load_frame(1'b1);
        run_frame(32'h1000_0000);
        compare_memory();
        end_test();

        begin_test("same frame, random valid and ready");
        random_mode = 1'b1;
        load_frame(1'b0);
        run_frame(32'h1000_0000);
        compare_memory();
        end_test();

        // Bursts recorded during the previous frame
        begin_test("burst format");
        if (burst_addrs.size() != FRAME_BURSTS) begin
            $display("CHECK FAILED %s: burst count expected %0d actual %0d",
                     test_name, FRAME_BURSTS, burst_addrs.size());
            errors++;
        end
        for (int i = 0; i < burst_addrs.size(); i++) begin
            if (burst_addrs[i] !== current_base + addr_t'(16 * BL * i)) begin
                $display("CHECK FAILED %s: burst %0d address expected %h actual %h", test_name,
                         i, current_base + addr_t'(16 * BL * i), burst_addrs[i]);
                errors++;
            end
            if (i < burst_beats.size() && burst_beats[i] != BL) begin
                $display("CHECK FAILED %s: burst %0d length expected %0d actual %0d",
                         test_name, i, BL, burst_beats[i]);
                errors++;
            end
        end
        end_test();

        begin_test("disable_dma blocks frame start");
        load_frame(1'b1);
        current_base  = 32'h2000_0400;
        dma_base_addr = current_base;
        disable_dma   = 1'b1;
        buffer_full   = 1'b1;
        test_errors   = errors;
        begin
            int aw_before;
            int done_before;
            aw_before   = aw_cycles;
            done_before = done_count;
            repeat (50) @(negedge clock);
            if (aw_cycles != aw_before || done_count != done_before) begin
                $display("ERROR: %s: the engine wrote while disable_dma was high", test_name);
                errors++;
            end
        end
        disable_dma = 1'b0;
        wait_started();
        buffer_full = 1'b0;
        wait_done();
        compare_memory();
        end_test();

        begin_test("SLVERR sets a sticky error");
        load_frame(1'b1);
        error_burst = 2;
        run_frame(32'h3000_0000);
        error_burst = -1;
        if (dma_error !== 1'b1) begin
            $display("CHECK FAILED %s: dma_error expected 1 actual %b", test_name, dma_error);
            errors++;
        end
        compare_memory();
        load_frame(1'b1);
        buffer_full = 1'b1;
        wait_started();
        buffer_full = 1'b0;
        if (dma_error !== 1'b0) begin
            $display("CHECK FAILED %s: dma_error at next start expected 0 actual %b",
                     test_name, dma_error);
            errors++;
        end
        wait_done();
        compare_memory();
        end_test();

        begin_test("second frame at a new base");
        load_frame(1'b1);
        run_frame(32'h4000_1240);
        compare_memory();
        if (dma_error !== 1'b0) begin
            $display("CHECK FAILED %s: dma_error expected 0 actual %b", test_name, dma_error);
            errors++;
        end
        end_test();

        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
